// ==== Makefile ====
# Verilator build and run of the 6502 core testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module cpu_tb -Mdir obj_dir
	./obj_dir/Vcpu_tb 2>&1 | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== hdl/cpu.sv ====
// Top level of the cut-down 6502 core
// Separate read and write buses; rdata must hold the byte at the address
// driven in the previous cycle
// we high stores wdata at addr on that clock edge
`timescale 1ns/1ps

module cpu (
    input  logic           clk,
    input  logic           reset,
    output cpu_pkg::addr_t addr,
    input  cpu_pkg::data_t rdata,
    output cpu_pkg::data_t wdata,
    output logic           we
);
    import cpu_pkg::*;

    addr_mode_t mode;
    ctl_t       ctl;
    cpu_state_t state;
    alu_res_t   alu;
    flags_t     flags;
    logic       cond_true;
    data_t      ai;
    data_t      bi;
    logic       ci;
    alu_op_t    op;
    logic       backwards;                      // Offset sign for BRA1

    cpu_alu u_alu (
        .clk (clk),
        .op  (op),
        .ai  (ai),
        .bi  (bi),
        .ci  (ci),
        .alu (alu)
    );

    cpu_decode u_decode (
        .clk   (clk),
        .reset (reset),
        .state (state),
        .rdata (rdata),
        .mode  (mode),
        .ctl   (ctl)
    );

    cpu_sequencer u_sequencer (
        .clk       (clk),
        .reset     (reset),
        .mode      (mode),
        .cond_true (cond_true),
        .alu       (alu),
        .backwards (backwards),
        .state     (state)
    );

    cpu_datapath u_datapath (
        .clk       (clk),
        .reset     (reset),
        .state     (state),
        .ctl       (ctl),
        .flags     (flags),
        .rdata     (rdata),
        .alu       (alu),
        .ai        (ai),
        .bi        (bi),
        .ci        (ci),
        .op        (op),
        .backwards (backwards),
        .addr      (addr),
        .wdata     (wdata),
        .we        (we)
    );

    cpu_status u_status (
        .clk       (clk),
        .reset     (reset),
        .state     (state),
        .ctl       (ctl),
        .alu       (alu),
        .flags     (flags),
        .cond_true (cond_true)
    );

endmodule

// ==== hdl/cpu_alu.sv ====
// 8-bit ALU of the 6502 core, binary mode only
// All outputs are registered and valid one cycle after the inputs
// co and v are only meaningful for ALU_ADD and ALU_SUB
`timescale 1ns/1ps

module cpu_alu (
    input  logic              clk,
    input  cpu_pkg::alu_op_t  op,
    input  cpu_pkg::data_t    ai,
    input  cpu_pkg::data_t    bi,
    input  logic              ci,
    output cpu_pkg::alu_res_t alu
);
    import cpu_pkg::*;

    data_t      b_eff;                          // bi after optional inversion
    logic [8:0] sum;                            // Adder with carry out in bit 8
    data_t      res;

    always_comb begin
        b_eff = (op == ALU_SUB) ? ~bi : bi;     // Subtract as ai + ~bi + ci
        sum   = {1'b0, ai} + {1'b0, b_eff} + {8'd0, ci};
        case (op)
            ALU_OR:  res = ai | bi;
            ALU_AND: res = ai & bi;
            ALU_EOR: res = ai ^ bi;
            default: res = sum[7:0];            // ADD and SUB
        endcase
    end

    always_ff @(posedge clk) begin
        alu.result <= res;
        alu.co     <= sum[8];
        alu.v      <= (ai[7] == b_eff[7]) && (sum[7] != ai[7]);  // Same signs in, other out
        alu.z      <= (res == '0);
        alu.n      <= res[7];
    end

endmodule

// ==== hdl/cpu_datapath.sv ====
// Program counter, address generator, register file and ALU input muxes
// addr, wdata and we are combinational from the state
// Memory is synchronous, so rdata belongs to the address of the cycle before
// The register file is written only in DECODE, from the ALU result
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_datapath (
    input  logic                clk,
    input  logic                reset,
    input  cpu_pkg::cpu_state_t state,
    input  cpu_pkg::ctl_t       ctl,
    input  cpu_pkg::flags_t     flags,
    input  cpu_pkg::data_t      rdata,
    input  cpu_pkg::alu_res_t   alu,
    output cpu_pkg::data_t      ai,
    output cpu_pkg::data_t      bi,
    output logic                ci,
    output cpu_pkg::alu_op_t    op,
    output logic                backwards,
    output cpu_pkg::addr_t      addr,
    output cpu_pkg::data_t      wdata,
    output logic                we
);
    import cpu_pkg::*;

    addr_t pc;
    addr_t pc_temp;                             // PC before increment
    logic  pc_inc;
    data_t abl;                                 // Previous address, low byte
    data_t abh;                                 // Previous address, high byte
    data_t regs [0:2];                          // A, X, Y
    data_t src_val;                             // Selected source register

    assign src_val = regs[ctl.src_reg];

    // PC base value
    always_comb begin
        case (state)
            VEC:     pc_temp = `CPU_RESET_VECTOR;
            JMP1:    pc_temp = {rdata, alu.result};  // High byte with latched low
            BRA1:    pc_temp = {abh, alu.result};
            BRA2:    pc_temp = {alu.result, pc[7:0]};
            default: pc_temp = pc;
        endcase
    end

    always_comb begin
        case (state)
            VEC, DECODE, ABS0, FETCH,
            BRA0, BRA2, JMP1: pc_inc = 1'b1;
            BRA1:             pc_inc = alu.co ~^ backwards;  // Done unless page crossed
            default:          pc_inc = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= `CPU_RESET_VECTOR;
        end else begin
            pc <= pc_temp + {15'd0, pc_inc};
        end
    end

    // Address generator
    always_comb begin
        case (state)
            VEC:        addr = `CPU_RESET_VECTOR;
            JMP1, ABS1: addr = {rdata, alu.result};
            BRA1:       addr = {abh, alu.result};
            BRA2:       addr = {alu.result, abl};
            ZP0:        addr = {`CPU_ZERO_PAGE, rdata};
            REG:        addr = {abh, abl};      // Opcode after a one-byte op
            default:    addr = pc;
        endcase
    end

    always_ff @(posedge clk) begin
        abl <= addr[7:0];
        abh <= addr[15:8];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            backwards <= 1'b0;
        end else if (state == BRA0) begin
            backwards <= rdata[7];              // Sign of branch offset
        end
    end

    always_ff @(posedge clk) begin
        if (state == DECODE && ctl.load_reg) begin
            regs[ctl.dst_reg] <= alu.result;
        end
    end

    assign wdata = src_val;
    assign we    = (state == ZP0 || state == ABS1) && ctl.store;

    // ALU inputs
    always_comb begin
        ai = '0;
        bi = rdata;
        ci = 1'b0;
        op = ALU_ADD;                           // Passes rdata for JMP and ABS
        case (state)
            FETCH: begin
                ai = ctl.load_only ? '0 : src_val;
                ci = ctl.compare ? 1'b1 : (ctl.load_only ? 1'b0 : flags.c);
                op = ctl.alu_op;
            end
            REG: begin
                ai = src_val;
                bi = '0;
                ci = ctl.inc;                   // DEX and DEY subtract zero
                op = ctl.alu_op;
            end
            BRA0: begin
                ai = rdata;                     // Offset
                bi = pc[7:0];
            end
            BRA1: begin
                ai = abh;
                bi = '0;
                ci = alu.co;
                op = backwards ? ALU_SUB : ALU_ADD;  // Carry or borrow into PCH
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== hdl/cpu_decode.sv ====
// Opcode decoder for the supported 6502 subset
// mode is combinational from rdata and only meaningful in DECODE
// ctl is latched in DECODE and holds until the next DECODE
// Opcodes outside the subset give MODE_NONE and clear every control
`timescale 1ns/1ps

module cpu_decode (
    input  logic                clk,
    input  logic                reset,
    input  cpu_pkg::cpu_state_t state,
    input  cpu_pkg::data_t      rdata,
    output cpu_pkg::addr_mode_t mode,
    output cpu_pkg::ctl_t       ctl
);
    import cpu_pkg::*;

    ctl_t dec;                                  // Controls for opcode on rdata

    // Addressing mode, first matching row wins
    always_comb begin
        casez (rdata)
            8'h4c:         mode = MODE_JUMP;    // JMP abs
            8'h89:         mode = MODE_NONE;    // No STA immediate
            8'b00?1_1000:  mode = MODE_REG;     // CLC, SEC
            8'b100?_1000,
            8'b1010_1000,
            8'b11?0_1000:  mode = MODE_REG;     // DEY, TYA, TAY, INY, INX
            8'b1000_1010,
            8'b1010_1010,
            8'b1100_1010:  mode = MODE_REG;     // TXA, TAX, DEX
            8'b1010_00?0,
            8'b???0_1001:  mode = MODE_IMM;     // LDY, LDX and the 9 column
            8'b???0_0101,
            8'b10?0_01?0:  mode = MODE_ZP;      // A group and X/Y zp
            8'b???0_1101,
            8'b10?0_11?0:  mode = MODE_ABS;     // A group and X/Y abs
            8'b???1_0000:  mode = MODE_BRANCH;  // Odd 0 column
            default:       mode = MODE_NONE;
        endcase
    end

    // Instruction controls from the opcode bit patterns
    always_comb begin
        dec           = '0;
        dec.alu_op    = ALU_ADD;
        dec.cond_code = rdata[7:5];             // Flag select and polarity
        if (rdata[1:0] == 2'b01) begin          // Accumulator group
            case (rdata[7:5])
                3'b000:  dec.alu_op = ALU_OR;
                3'b001:  dec.alu_op = ALU_AND;
                3'b010:  dec.alu_op = ALU_EOR;
                3'b110,
                3'b111:  dec.alu_op = ALU_SUB;  // CMP, SBC
                default: dec.alu_op = ALU_ADD;  // ADC, STA, LDA
            endcase
        end
        if (rdata == 8'h88 || rdata == 8'hca) begin
            dec.alu_op = ALU_SUB;               // DEY, DEX count down
        end

        casez (rdata)
            8'b100?_?110,
            8'h8a, 8'he8, 8'hca: dec.src_reg = SEL_X;  // STX, TXA, INX, DEX
            8'b100?_?100,
            8'h98, 8'hc8, 8'h88: dec.src_reg = SEL_Y;  // STY, TYA, INY, DEY
            default:             dec.src_reg = SEL_A;
        endcase

        casez (rdata)
            8'b1010_??10,
            8'he8, 8'hca:        dec.dst_reg = SEL_X;  // LDX, TAX, INX, DEX
            8'b1010_?100,
            8'b1010_?000,
            8'h88, 8'hc8:        dec.dst_reg = SEL_Y;  // LDY, TAY, DEY, INY
            default:             dec.dst_reg = SEL_A;
        endcase

        dec.load_reg  = (rdata ==? 8'b0???_??01)    // ORA, AND, EOR, ADC
                     || (rdata ==? 8'b1?1?_??01)    // LDA, SBC
                     || (rdata ==? 8'b1010_???0)    // LDX, LDY, TAX, TAY
                     || (rdata ==? 8'b100?_10?0)    // DEY, TXA, TYA
                     || (rdata ==? 8'b11?0_1000)    // INY, INX
                     || (rdata == 8'hca);           // DEX
        dec.load_only = (rdata[7:5] == 3'b101);
        dec.store     = (rdata ==? 8'b100?_?1?0) || (rdata ==? 8'b100?_??01);
        dec.compare   = (rdata ==? 8'b110?_??01);
        dec.adc_sbc   = (rdata ==? 8'b?11?_??01);
        dec.inc       = (rdata ==? 8'b11?0_1000);
        dec.sec       = (rdata == 8'h38);
        dec.clc       = (rdata == 8'h18);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctl <= '0;
        end else if (state == DECODE) begin
            if (mode == MODE_NONE) begin
                ctl <= '0;                      // NOP touches nothing
            end else begin
                ctl <= dec;
            end
        end
    end

endmodule

// ==== hdl/cpu_pkg.sv ====
// Shared types for the cut-down 6502 core
// Binary arithmetic only, with no stack, interrupt or decimal state
// The state and mode encodings are internal and may be renumbered freely
`include "cpu_defines.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_W-1:0] data_t;     // One data byte
    typedef logic [`CPU_ADDR_W-1:0] addr_t;     // One bus address

    typedef enum logic [1:0] {
        SEL_A,
        SEL_X,
        SEL_Y
    } reg_sel_t;

    typedef enum logic [2:0] {
        ALU_OR,
        ALU_AND,
        ALU_EOR,
        ALU_ADD,
        ALU_SUB                                 // ai + ~bi + ci
    } alu_op_t;

    typedef enum logic [3:0] {
        VEC,                                    // Put reset vector address out
        DECODE,                                 // Opcode on rdata
        FETCH,                                  // Next opcode out, ALU op on operand
        REG,                                    // Register to register op
        ZP0,                                    // Zero-page data access
        ABS0,                                   // Fetch high address byte
        ABS1,                                   // Absolute data access
        BRA0,                                   // Offset plus PCL
        BRA1,                                   // Target in same page
        BRA2,                                   // Fix up PCH on page cross
        JMP0,                                   // Fetch target high byte
        JMP1                                    // Target address out
    } cpu_state_t;

    typedef enum logic [2:0] {
        MODE_IMM,
        MODE_ZP,
        MODE_ABS,
        MODE_REG,
        MODE_BRANCH,
        MODE_JUMP,
        MODE_NONE                               // Runs as two-cycle NOP
    } addr_mode_t;

    typedef struct packed {
        alu_op_t    alu_op;                     // Op used in FETCH and REG
        reg_sel_t   src_reg;                    // ALU operand and store data
        reg_sel_t   dst_reg;                    // Written at next DECODE
        logic       load_reg;                   // Result goes to dst_reg
        logic       load_only;                  // LDA, LDX or LDY
        logic       store;                      // STA, STX or STY
        logic       compare;                    // CMP
        logic       adc_sbc;                    // ADC or SBC
        logic       inc;                        // INX or INY
        logic       sec;
        logic       clc;
        logic [2:0] cond_code;                  // Opcode bits 7:5
    } ctl_t;

    typedef struct packed {
        data_t result;
        logic  co;                              // Carry out
        logic  v;                               // Signed overflow
        logic  z;
        logic  n;
    } alu_res_t;

    typedef struct packed {
        logic c;
        logic z;
        logic v;
        logic n;
    } flags_t;

endpackage

// ==== hdl/cpu_sequencer.sv ====
// Microcode state machine of the 6502 core
// One state per clock, no stalls since there is no RDY input
// Reset holds VEC, then the vector is read through the JMP states
`timescale 1ns/1ps

module cpu_sequencer (
    input  logic                clk,
    input  logic                reset,
    input  cpu_pkg::addr_mode_t mode,
    input  logic                cond_true,
    input  cpu_pkg::alu_res_t   alu,
    input  logic                backwards,
    output cpu_pkg::cpu_state_t state
);
    import cpu_pkg::*;

    cpu_state_t next_state;

    always_comb begin
        case (state)
            VEC:     next_state = JMP0;
            JMP0:    next_state = JMP1;
            JMP1:    next_state = DECODE;
            DECODE: begin
                case (mode)
                    MODE_IMM:    next_state = FETCH;
                    MODE_ZP:     next_state = ZP0;
                    MODE_ABS:    next_state = ABS0;
                    MODE_BRANCH: next_state = BRA0;
                    MODE_JUMP:   next_state = JMP0;
                    default:     next_state = REG;  // Register ops and NOPs
                endcase
            end
            ZP0:     next_state = FETCH;
            ABS0:    next_state = ABS1;
            ABS1:    next_state = FETCH;
            FETCH:   next_state = DECODE;
            REG:     next_state = DECODE;
            BRA0:    next_state = cond_true ? BRA1 : DECODE;
            BRA1:    next_state = (alu.co ^ backwards) ? BRA2 : DECODE;  // Page crossed
            BRA2:    next_state = DECODE;
            default: next_state = VEC;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= VEC;
        end else begin
            state <= next_state;
        end
    end

endmodule

// ==== hdl/cpu_status.sv ====
// Status flags C, Z, V, N and the branch condition
// Flags from an ALU result update at DECODE, when ctl still holds
// the previous instruction; CLC and SEC act at the end of REG
`timescale 1ns/1ps

module cpu_status (
    input  logic                clk,
    input  logic                reset,
    input  cpu_pkg::cpu_state_t state,
    input  cpu_pkg::ctl_t       ctl,
    input  cpu_pkg::alu_res_t   alu,
    output cpu_pkg::flags_t     flags,
    output logic                cond_true
);
    import cpu_pkg::*;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flags <= '0;
        end else if (state == DECODE) begin
            if (ctl.adc_sbc || ctl.compare) begin
                flags.c <= alu.co;              // Carry, or no borrow for SBC and CMP
            end
            if (ctl.load_reg || ctl.compare) begin
                flags.z <= alu.z;
                flags.n <= alu.n;
            end
            if (ctl.adc_sbc) begin
                flags.v <= alu.v;
            end
        end else if (state == REG) begin
            if (ctl.sec) begin
                flags.c <= 1'b1;
            end
            if (ctl.clc) begin
                flags.c <= 1'b0;
            end
        end
    end

    always_comb begin
        case (ctl.cond_code)
            3'b000:  cond_true = ~flags.n;      // BPL
            3'b001:  cond_true = flags.n;       // BMI
            3'b010:  cond_true = ~flags.v;      // BVC
            3'b011:  cond_true = flags.v;       // BVS
            3'b100:  cond_true = ~flags.c;      // BCC
            3'b101:  cond_true = flags.c;       // BCS
            3'b110:  cond_true = ~flags.z;      // BNE
            default: cond_true = flags.z;       // BEQ
        endcase
    end

endmodule

// ==== include/cpu_defines.svh ====
// Core-wide constants for the cut-down 6502
// Widths follow the instruction set and are not meant to be changed
// The reset vector is read low byte first, high byte at the next address
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`define CPU_DATA_W       8          // Data bus and register width
`define CPU_ADDR_W       16         // Address bus width
`define CPU_RESET_VECTOR 16'hfffc   // Low byte of the reset vector
`define CPU_ZERO_PAGE    8'h00      // High address byte in zero-page mode

`endif

// ==== verification/cpu_assert.sv ====
// Bus rules of the 6502 core, sampled on the rising clock edge
// Bound to every instance of cpu
// Vector checks expect reset to last at least two cycles
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_assert (
    input logic           clk,
    input logic           reset,
    input cpu_pkg::addr_t addr,
    input logic           we
);

    we_low_in_reset: assert property (@(posedge clk) reset |-> !we)
        else $error("we high while reset is active");

    we_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(we))
        else $error("we has an unknown value");

    // A store lasts exactly one cycle
    we_one_cycle: assert property (@(posedge clk) disable iff (reset) we |=> !we)
        else $error("we high for more than one cycle");

    vector_low: assert property (@(posedge clk) $fell(reset) |-> addr == `CPU_RESET_VECTOR)
        else $error("first address after reset is not the vector low byte");

    vector_high: assert property (@(posedge clk) disable iff (reset)
        ($past(reset, 2) && !$past(reset)) |-> addr == `CPU_RESET_VECTOR + 16'd1)
        else $error("second address after reset is not the vector high byte");

endmodule

bind cpu cpu_assert u_cpu_assert (
    .clk   (clk),
    .reset (reset),
    .addr  (addr),
    .we    (we)
);

// ==== verification/cpu_tb.sv ====
// Testbench for the cut-down 6502 core with a 64 KiB synchronous memory
// Each test builds a program, resets the core and runs to a final JMP to itself
// Writes are compared in order against a list of expected address and data pairs
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_tb;
    import cpu_pkg::*;

    logic   clk;
    logic   reset;
    addr_t  addr;
    data_t  rdata;
    data_t  wdata;
    logic   we;
    data_t  mem [0:65535];
    addr_t  exp_addr [$];                       // Expected writes in order
    data_t  exp_data [$];
    addr_t  pc_build;                           // Next free program byte
    int     instr_count;
    int     errors;
    int     n_pass;
    int     n_fail;
    time    deadline;                           // Watchdog limit of the current test
    integer seed;
    logic   model_c;                            // Reference carry and overflow
    logic   model_v;

    cpu u_cpu (
        .clk   (clk),
        .reset (reset),
        .addr  (addr),
        .rdata (rdata),
        .wdata (wdata),
        .we    (we)
    );

    always #2 clk = ~clk;                       // 4 ns period

    always @(posedge clk) begin
        rdata <= mem[addr];                     // Data one cycle after address
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // Compare each write with the head of the expected list
    always @(negedge clk) begin
        if (we) begin
            if (exp_addr.size() == 0) begin
                $display("unexpected write of %h to address %h", wdata, addr);
                errors++;
            end else begin
                assert (addr === exp_addr[0]) else begin
                    $display("MISMATCH addr expected %h got %h", exp_addr[0], addr);
                    errors++;
                end
                assert (wdata === exp_data[0]) else begin
                    $display("MISMATCH wdata expected %h got %h", exp_data[0], wdata);
                    errors++;
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    initial begin
        deadline = 2000;
        while ($time <= deadline) @(posedge clk);
        $display("watchdog expired, a program did not reach its final jump in time");
        $display("TESTS FAILED");
        $finish;
    end

    task automatic put_byte(input data_t b);
        mem[pc_build] = b;
        pc_build++;
    endtask

    task automatic implied(input data_t opc);
        put_byte(opc);
        instr_count++;
    endtask

    task automatic with_operand(input data_t opc, input data_t arg);
        put_byte(opc);
        put_byte(arg);
        instr_count++;
    endtask

    task automatic with_address(input data_t opc, input addr_t a);
        put_byte(opc);
        put_byte(a[7:0]);
        put_byte(a[15:8]);
        instr_count++;
    endtask

    task automatic expect_write(input addr_t a, input data_t d);
        exp_addr.push_back(a);
        exp_data.push_back(d);
    endtask

    task automatic check_addr(input addr_t expv);
        assert (addr === expv) else begin
            $display("MISMATCH addr expected %h got %h", expv, addr);
            errors++;
        end
    endtask

    task automatic start_program(input addr_t vector);
        reset = 1'b1;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = data_t'(i) ^ data_t'(i >> 8) ^ 8'ha5;  // Depends on both address bytes
        end
        mem[`CPU_RESET_VECTOR]         = vector[7:0];
        mem[`CPU_RESET_VECTOR + 16'd1] = vector[15:8];
        exp_addr.delete();
        exp_data.delete();
        pc_build    = vector;
        instr_count = 0;
        model_c     = 1'b0;
        model_v     = 1'b0;
    endtask

    task automatic run_program(input string name, input addr_t vector);
        addr_t halt;
        int    errors_at_start;
        halt   = pc_build;
        with_address(8'h4c, halt);              // JMP to itself ends the program
        errors_at_start = errors;
        deadline = $time + (instr_count * 8 + 16) * 4;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_addr(`CPU_RESET_VECTOR);          // VEC
        @(negedge clk);
        check_addr(`CPU_RESET_VECTOR + 16'd1);  // JMP0
        @(negedge clk);
        check_addr(vector);                     // JMP1
        while (addr !== halt) @(negedge clk);
        assert (exp_addr.size() == 0) else begin
            $display("%0d expected writes never happened", exp_addr.size());
            errors++;
        end
        if (errors == errors_at_start) begin
            n_pass++;
            $display("%s: ok", name);
        end else begin
            n_fail++;
            $display("%s: %0d errors", name, errors - errors_at_start);
        end
    endtask

    // One ALU case, then C and V exposed through branches over stores
    task automatic alu_case(input data_t base, input int k);
        data_t      a;
        data_t      b;
        data_t      r;
        logic       cin;
        logic [8:0] s;
        a   = data_t'($random(seed));
        b   = data_t'($random(seed));
        cin = 1'($random(seed));
        with_operand(8'ha9, a);
        implied(cin ? 8'h38 : 8'h18);           // SEC or CLC
        case ((k / 6) % 3)
            0: with_operand(base | 8'h09, b);
            1: begin
                mem[16'h0040 + k] = b;
                with_operand(base | 8'h05, data_t'(8'h40 + k));
            end
            default: begin
                mem[16'h6000 + k] = b;
                with_address(base | 8'h0d, addr_t'(16'h6000 + k));
            end
        endcase
        model_c = cin;
        case (base)
            8'h00: r = a | b;
            8'h20: r = a & b;
            8'h40: r = a ^ b;
            8'h60: begin
                s       = {1'b0, a} + {1'b0, b} + {8'd0, cin};
                r       = s[7:0];
                model_c = s[8];
                model_v = (a[7] == b[7]) && (r[7] != a[7]);
            end
            8'he0: begin
                r       = a - b - {7'd0, ~cin};  // Borrow is the inverted carry
                model_c = ({1'b0, a} >= {1'b0, b} + {8'd0, ~cin});
                model_v = (a[7] != b[7]) && (r[7] != a[7]);
            end
            default: begin
                r       = a;                    // CMP leaves A alone
                model_c = (a >= b);
            end
        endcase
        with_operand(8'h85, 8'h80);
        expect_write(16'h0080, r);
        with_operand(8'h90, 8'h02);             // BCC over STY
        with_operand(8'h84, 8'h81);
        with_operand(8'hb0, 8'h02);             // BCS over STX
        with_operand(8'h86, 8'h81);
        expect_write(16'h0081, {7'd0, model_c});
        with_operand(8'h50, 8'h02);             // BVC over STY
        with_operand(8'h84, 8'h82);
        with_operand(8'h70, 8'h02);             // BVS over STX
        with_operand(8'h86, 8'h82);
        expect_write(16'h0082, {7'd0, model_v});
    endtask

    initial begin
        data_t a;
        data_t x;
        data_t y;
        data_t bases [0:5];
        addr_t loop_top;
        clk    = 1'b0;
        reset  = 1'b1;
        rdata  = '0;
        errors = 0;
        n_pass = 0;
        n_fail = 0;
        seed   = 32'h807c_c7e4;
        bases  = '{8'h00, 8'h20, 8'h40, 8'h60, 8'hc0, 8'he0};  // ORA AND EOR ADC CMP SBC

        start_program(16'h0200);
        run_program("reset vector", 16'h0200);

        start_program(16'h0300);
        a = data_t'($random(seed));
        x = data_t'($random(seed));
        y = data_t'($random(seed));
        with_operand(8'ha9, a);
        with_operand(8'ha2, x);
        with_operand(8'ha0, y);
        with_operand(8'h85, 8'h10);
        expect_write(16'h0010, a);
        with_operand(8'h86, 8'h11);
        expect_write(16'h0011, x);
        with_operand(8'h84, 8'h12);
        expect_write(16'h0012, y);
        with_address(8'h8d, 16'h4567);
        expect_write(16'h4567, a);
        with_address(8'h8e, 16'h4568);
        expect_write(16'h4568, x);
        with_address(8'h8c, 16'h4569);
        expect_write(16'h4569, y);
        mem[16'h0030] = a ^ 8'h3c;
        mem[16'h5100] = x ^ 8'hc3;
        mem[16'h0031] = y ^ 8'h81;
        with_operand(8'ha5, 8'h30);             // LDA zp
        with_address(8'h8d, 16'h5000);
        expect_write(16'h5000, a ^ 8'h3c);
        with_address(8'hae, 16'h5100);          // LDX abs
        with_operand(8'h86, 8'h14);
        expect_write(16'h0014, x ^ 8'hc3);
        with_operand(8'ha4, 8'h31);             // LDY zp
        with_address(8'h8c, 16'h5001);
        expect_write(16'h5001, y ^ 8'h81);
        run_program("loads and stores", 16'h0300);

        start_program(16'h0400);
        with_operand(8'ha2, 8'h00);             // X and Y feed the flag stores
        with_operand(8'ha0, 8'h01);
        for (int k = 0; k < 24; k++) begin
            alu_case(bases[k % 6], k);
        end
        run_program("alu operations", 16'h0400);

        start_program(16'h0800);
        a = data_t'($random(seed));
        x = data_t'($random(seed));
        y = data_t'($random(seed));
        with_operand(8'ha2, 8'h00);
        implied(8'hca);                         // DEX wraps to FF
        with_operand(8'h86, 8'h90);
        expect_write(16'h0090, 8'hff);
        with_operand(8'ha0, 8'hff);
        implied(8'hc8);                         // INY wraps to 00
        with_operand(8'h84, 8'h91);
        expect_write(16'h0091, 8'h00);
        with_operand(8'ha2, x);
        implied(8'he8);
        implied(8'he8);
        implied(8'hca);
        with_operand(8'h86, 8'h92);
        expect_write(16'h0092, x + 8'd1);
        with_operand(8'ha0, y);
        implied(8'h88);
        with_operand(8'h84, 8'h93);
        expect_write(16'h0093, y - 8'd1);
        with_operand(8'ha9, a);
        implied(8'haa);                         // TAX
        implied(8'ha8);                         // TAY
        with_operand(8'h86, 8'h94);
        expect_write(16'h0094, a);
        with_operand(8'h84, 8'h95);
        expect_write(16'h0095, a);
        with_operand(8'ha2, x);
        implied(8'h8a);                         // TXA
        with_operand(8'h85, 8'h96);
        expect_write(16'h0096, x);
        with_operand(8'ha0, y);
        implied(8'h98);                         // TYA
        with_operand(8'h85, 8'h97);
        expect_write(16'h0097, y);
        with_operand(8'ha9, a);
        with_operand(8'ha2, x);
        implied(8'hea);                         // Opcodes outside the subset
        implied(8'h0a);
        implied(8'h1a);
        with_operand(8'h85, 8'h98);
        expect_write(16'h0098, a);
        with_operand(8'h86, 8'h99);
        expect_write(16'h0099, x);
        with_operand(8'h84, 8'h9a);
        expect_write(16'h009a, y);
        run_program("register operations", 16'h0800);

        start_program(16'h0a00);
        with_operand(8'ha2, 8'h05);
        loop_top = pc_build;
        with_operand(8'h86, 8'ha0);
        implied(8'hca);
        with_operand(8'hd0, data_t'(loop_top - pc_build - 16'd2));  // Backward BNE
        instr_count += 12;                      // Four more passes of three
        for (int i = 5; i > 0; i--) begin
            expect_write(16'h00a0, data_t'(i));
        end
        with_operand(8'hd0, 8'h02);             // Not taken since Z is set
        with_operand(8'h86, 8'ha1);
        expect_write(16'h00a1, 8'h00);
        with_operand(8'hf0, 8'h02);             // Taken over STX
        with_operand(8'h86, 8'ha2);
        with_operand(8'ha9, 8'h80);
        with_operand(8'h10, 8'h02);             // BPL not taken
        with_operand(8'h85, 8'ha4);
        expect_write(16'h00a4, 8'h80);
        with_operand(8'h30, 8'h02);             // BMI taken
        with_operand(8'h85, 8'ha5);
        with_address(8'h4c, 16'h0cf8);
        with_operand(8'h85, 8'ha8);             // Never reached after JMP
        pc_build = 16'h0cf8;
        with_operand(8'ha9, 8'h33);
        with_operand(8'hd0, 8'h10);             // Crosses into page 0d
        with_operand(8'h85, 8'ha6);
        pc_build = 16'h0d0c;
        with_operand(8'h85, 8'ha7);
        expect_write(16'h00a7, 8'h33);
        run_program("branches and jmp", 16'h0a00);

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 n_pass + n_fail, n_pass, n_fail, errors);
        if (errors == 0 && n_fail == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
hdl/cpu_pkg.sv
hdl/cpu_alu.sv
hdl/cpu_decode.sv
hdl/cpu_sequencer.sv
hdl/cpu_datapath.sv
hdl/cpu_status.sv
hdl/cpu.sv
verification/cpu_assert.sv
verification/cpu_tb.sv
